// ==== project.f ====
+incdir+hdl
hdl/smc_mac_pkg.sv
hdl/smc_access_counter.sv
hdl/smc_read_assembler.sv
hdl/smc_write_lane_mux.sv
hdl/smc_mac_lite.sv
testbench/tb_smc_mac_lite.sv

// ==== Bender.yml ====
package:
  name: smc_mac_lite

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/smc_mac_pkg.sv
      - hdl/smc_access_counter.sv
      - hdl/smc_read_assembler.sv
      - hdl/smc_write_lane_mux.sv
      - hdl/smc_mac_lite.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_smc_mac_lite.sv

// ==== testbench/tb_smc_mac_lite.sv ====
// testbench for the smc multiple-access control block
// random byte, halfword and word transfers checked against a behavioral model

`timescale 1ns/1ns

`include "smc_mac_consts.svh"

module tb_smc_mac_lite;

  localparam int NUM_XFERS   = 50;                // transfers per random test
  localparam int NUM_TESTS   = 2;                 // random tests after reset
  localparam int MAX_GAP     = 3;                 // idle cycles between transfers
  localparam int MAX_WAIT    = 1;                 // le cycles before an access
  // gap, address cycle, four accesses with waits, closing idle
  localparam int WORST_XFER  = MAX_GAP + 1 + 4 * (MAX_WAIT + 1) + 1;
  localparam int CYCLE_LIMIT = 2 * WORST_XFER * NUM_XFERS * NUM_TESTS;

  logic                     sys_clk8;
  logic                     n_sys_reset8;
  logic                     valid_access;
  smc_mac_pkg::xfer_size_t  xfer_size;
  logic                     smc_done;
  smc_mac_pkg::smc_state_t  smc_nextstate;
  logic                     latch_data;
  smc_mac_pkg::smc_byte_t   data_smc;
  smc_mac_pkg::smc_word_t   write_data;
  smc_mac_pkg::acc_cnt_t    r_num_access;
  logic                     mac_done;
  smc_mac_pkg::xfer_size_t  v_xfer_size;
  smc_mac_pkg::smc_word_t   read_data;
  smc_mac_pkg::smc_word_t   smc_data;

  // model state
  smc_mac_pkg::acc_cnt_t    m_cnt;        // accesses still to go
  smc_mac_pkg::xfer_size_t  m_size;       // stored size
  smc_mac_pkg::smc_word_t   m_reg;        // assembled read bytes

  int check_cnt = 0;
  int error_cnt = 0;
  int test_cnt  = 0;
  int cycle_cnt = 0;
  int seed_val;

  smc_mac_lite DUT
  (
    .sys_clk8      (sys_clk8),
    .n_sys_reset8  (n_sys_reset8),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  // 20 ns clock
  initial
  begin
    sys_clk8 = 1'b0;
    forever #10 sys_clk8 = ~sys_clk8;
  end

  // ------------------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------------------
  always @(posedge sys_clk8)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // model
  // ------------------------------------------------------------------------

  // accesses after the first one
  function automatic smc_mac_pkg::acc_cnt_t load_value(input smc_mac_pkg::xfer_size_t sz);
    case (sz)
      smc_mac_pkg::XFER_32: return 2'd3;
      smc_mac_pkg::XFER_16: return 2'd1;
      default:              return 2'd0;
    endcase
  endfunction

  // lane picked by count with lanes above kept and lanes below cleared
  function automatic smc_mac_pkg::smc_word_t store_byte(input smc_mac_pkg::smc_word_t word,
                                                       input smc_mac_pkg::acc_cnt_t cnt,
                                                       input smc_mac_pkg::smc_byte_t b);
    smc_mac_pkg::smc_word_t keep;
    keep = 32'hffff_ffff << (8 * (int'(cnt) + 1));  // shift of 32 leaves nothing
    return (word & keep) | (smc_mac_pkg::smc_word_t'(b) << (8 * int'(cnt)));
  endfunction

  // byte or halfword copied across the word
  function automatic smc_mac_pkg::smc_word_t replicate(input smc_mac_pkg::smc_word_t word,
                                                      input smc_mac_pkg::xfer_size_t sz);
    if (sz == smc_mac_pkg::XFER_32)
      return word;
    else if (sz == smc_mac_pkg::XFER_16)
      return {word[15:0], word[15:0]};
    else
      return {word[7:0], word[7:0], word[7:0], word[7:0]};
  endfunction

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    assert (got === exp)
    else
    begin
      error_cnt++;
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // strobes low and size bus scrambled so the stored size is really used
  task automatic drive_idle();
    valid_access  = 1'b0;
    smc_done      = 1'b0;
    latch_data    = 1'b0;
    smc_nextstate = `SMC_IDLE;
    xfer_size     = smc_mac_pkg::xfer_size_t'($urandom_range(2, 0));
  endtask

  // one transfer of random size and direction
  task automatic run_transfer(input int max_gap);
    smc_mac_pkg::xfer_size_t sz;
    logic                    is_read;
    int                      n_acc;
    int                      n_wait;
    smc_mac_pkg::smc_byte_t  rd_byte;
    sz      = smc_mac_pkg::xfer_size_t'($urandom_range(2, 0));
    is_read = $urandom_range(1, 0);
    repeat ($urandom_range(max_gap, 0))
    begin
      @(negedge sys_clk8);
      drive_idle();
    end
    // address cycle
    @(negedge sys_clk8);
    drive_idle();
    valid_access = 1'b1;
    xfer_size    = sz;
    write_data   = $urandom;              // held to the end
    #1;
    check_eq(v_xfer_size, sz, "v_xfer_size in address cycle");
    m_size = sz;
    m_cnt  = load_value(sz);
    n_acc  = int'(m_cnt) + 1;
    for (int i = n_acc - 1; i >= 0; i--)
    begin
      n_wait = $urandom_range(MAX_WAIT, 0);
      repeat (n_wait)
      begin
        @(negedge sys_clk8);
        drive_idle();
        smc_nextstate = `SMC_LE;          // count holds without done
        #1;
        check_eq(r_num_access, m_cnt, "r_num_access while waiting");
        if (is_read)
          check_eq(read_data, replicate(m_reg, m_size), "read_data while waiting");
      end
      @(negedge sys_clk8);
      drive_idle();
      smc_done = 1'b1;
      if (i == 0)
        smc_nextstate = is_read ? `SMC_STORE : `SMC_IDLE;
      else
        smc_nextstate = `SMC_RW;
      rd_byte = $urandom;
      if (is_read)
      begin
        latch_data = 1'b1;
        data_smc   = rd_byte;
      end
      #1;
      check_eq(r_num_access, m_cnt, "r_num_access");
      check_eq(mac_done, (i == 0), "mac_done");
      check_eq(v_xfer_size, m_size, "v_xfer_size");
      if (is_read)
      begin
        // live byte in the low lane
        check_eq(read_data, replicate({m_reg[31:8], rd_byte}, m_size), "read_data");
        m_reg = store_byte(m_reg, m_cnt, rd_byte);
      end
      else
      begin
        check_eq(smc_data, (write_data >> (8 * i)) & 32'h0000_00ff, "smc_data");
      end
      if (i != 0)
        m_cnt = m_cnt - 2'd1;
    end
    @(negedge sys_clk8);
    drive_idle();
    #1;
    check_eq(mac_done, 1'b1, "mac_done after transfer");
    if (is_read)
      check_eq(read_data, replicate(m_reg, m_size), "completed read word");
  endtask

  task automatic run_test(input string name, input int max_gap);
    int errs_before;
    errs_before = error_cnt;
    for (int n = 0; n < NUM_XFERS; n++)
      run_transfer(max_gap);
    test_cnt++;
    $display("test %s: %0d transfers, %0d errors", name, NUM_XFERS, error_cnt - errs_before);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial
  begin
    seed_val      = $urandom(4);          // seeds the run
    n_sys_reset8  = 1'b0;
    valid_access  = 1'b0;
    xfer_size     = smc_mac_pkg::XFER_8;
    smc_done      = 1'b0;
    smc_nextstate = `SMC_IDLE;
    latch_data    = 1'b0;
    data_smc      = '0;
    write_data    = '0;
    m_cnt         = '0;
    m_size        = smc_mac_pkg::XFER_8;
    m_reg         = '0;
    repeat (5) @(posedge sys_clk8);
    @(negedge sys_clk8);
    n_sys_reset8 = 1'b1;
    #1;
    // reset state
    check_eq(mac_done, 1'b1, "mac_done after reset");
    check_eq(r_num_access, 0, "r_num_access after reset");
    check_eq(read_data, 0, "read_data after reset");
    test_cnt++;
    $display("test reset: %0d errors", error_cnt);
    run_test("random_gaps", MAX_GAP);
    run_test("back_to_back", 0);
    @(negedge sys_clk8);
    $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== hdl/smc_mac_lite.sv ====
// smc multiple-access control, top
// splits one internal transfer into byte accesses on the 8-bit memory bus

`timescale 1ns/1ns

`include "smc_mac_consts.svh"

module smc_mac_lite
(
  input  logic                     sys_clk8,       // system clock
  input  logic                     n_sys_reset8,   // async reset, active low
  input  logic                     valid_access,   // address cycle of new transfer
  input  smc_mac_pkg::xfer_size_t  xfer_size,      // valid with valid_access
  input  logic                     smc_done,       // end of one external access
  input  smc_mac_pkg::smc_state_t  smc_nextstate,  // fsm next state
  input  logic                     latch_data,     // read byte valid
  input  smc_mac_pkg::smc_byte_t   data_smc,       // external read byte
  input  smc_mac_pkg::smc_word_t   write_data,     // internal write word
  output smc_mac_pkg::acc_cnt_t    r_num_access,   // accesses still to go
  output logic                     mac_done,       // last access
  output smc_mac_pkg::xfer_size_t  v_xfer_size,    // size valid this cycle
  output smc_mac_pkg::smc_word_t   read_data,      // to internal bus
  output smc_mac_pkg::smc_word_t   smc_data        // to external bus
);

  smc_mac_pkg::xfer_size_t r_xfer_size;   // stored size, read side only

  // --------------------------------------------------------------------------
  // access count and size
  // --------------------------------------------------------------------------
  smc_access_counter u_counter
  (
    .sys_clk8      (sys_clk8),
    .n_sys_reset8  (n_sys_reset8),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .r_num_access  (r_num_access),
    .r_xfer_size   (r_xfer_size),
    .v_xfer_size   (v_xfer_size),
    .mac_done      (mac_done)
  );

  // --------------------------------------------------------------------------
  // read path
  // --------------------------------------------------------------------------
  smc_read_assembler u_read
  (
    .sys_clk8      (sys_clk8),
    .n_sys_reset8  (n_sys_reset8),
    .latch_data    (latch_data),
    .r_num_access  (r_num_access),
    .r_xfer_size   (r_xfer_size),
    .data_smc      (data_smc),
    .read_data     (read_data)
  );

  // --------------------------------------------------------------------------
  // write path
  // --------------------------------------------------------------------------
  smc_write_lane_mux u_write
  (
    .r_num_access  (r_num_access),
    .write_data    (write_data),
    .smc_data      (smc_data)
  );

endmodule

// ==== hdl/smc_write_lane_mux.sv ====
// smc write lane mux
// puts the write-data byte for the current access on the external bus

`timescale 1ns/1ns

`include "smc_mac_consts.svh"

module smc_write_lane_mux
(
  input  smc_mac_pkg::acc_cnt_t    r_num_access,   // selects the byte lane
  input  smc_mac_pkg::smc_word_t   write_data,     // held by the internal bus
  output smc_mac_pkg::smc_word_t   smc_data        // to external bus
);

  smc_mac_pkg::smc_byte_t lane;   // byte for this access

  // same lane order as the read side with msb first
  always_comb
  begin
    case (r_num_access)
      2'd3:    lane = write_data[31:24];
      2'd2:    lane = write_data[23:16];
      2'd1:    lane = write_data[15:8];
      default: lane = write_data[7:0];
    endcase
  end

  // upper lanes unused on the 8-bit bus
  assign smc_data = {{(`SMC_DATA_W - `SMC_BYTE_W){1'b0}}, lane};

endmodule

// ==== hdl/smc_read_assembler.sv ====
// smc read assembler
// collects external read bytes into a word and drives the internal read bus

`timescale 1ns/1ns

`include "smc_mac_consts.svh"

module smc_read_assembler
(
  input  logic                     sys_clk8,       // system clock
  input  logic                     n_sys_reset8,   // async reset, active low
  input  logic                     latch_data,     // data_smc valid this cycle
  input  smc_mac_pkg::acc_cnt_t    r_num_access,   // selects the byte lane
  input  smc_mac_pkg::xfer_size_t  r_xfer_size,    // stored transfer size
  input  smc_mac_pkg::smc_byte_t   data_smc,       // external read byte
  output smc_mac_pkg::smc_word_t   read_data       // to internal bus
);

  smc_mac_pkg::smc_word_t r_read_data;  // bytes gathered so far
  smc_mac_pkg::smc_word_t cur_word;     // register with live byte merged in

  // --------------------------------------------------------------------------
  // byte store
  // --------------------------------------------------------------------------
  // bytes arrive msb first, count 3 down to 0
  // lanes below the written one are cleared, lanes above are kept
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
    begin
      r_read_data <= '0;
    end
    else if (latch_data)
    begin
      case (r_num_access)
        2'd3:
        begin
          // first byte of a word, wipe the rest
          r_read_data <= {data_smc, {(`SMC_DATA_W - `SMC_BYTE_W){1'b0}}};
        end
        2'd2:
        begin
          r_read_data <= {r_read_data[31:24], data_smc, 16'h0};
        end
        2'd1:
        begin
          // first byte of a halfword lands here too
          r_read_data <= {r_read_data[31:16], data_smc, 8'h0};
        end
        default:
        begin
          r_read_data <= {r_read_data[31:8], data_smc};   // last byte
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // read bus
  // --------------------------------------------------------------------------

  // the last byte goes straight through in its latch cycle
  // so the word is complete without waiting a clock
  assign cur_word = latch_data ? {r_read_data[31:8], data_smc} : r_read_data;

  always_comb
  begin
    case (r_xfer_size)
      smc_mac_pkg::XFER_32:
      begin
        read_data = cur_word;
      end
      smc_mac_pkg::XFER_16:
      begin
        read_data = {2{cur_word[15:0]}};    // halfword on both lanes
      end
      default:
      begin
        read_data = {4{cur_word[7:0]}};     // byte on all four lanes
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // memory must drive the bus by the time the fsm samples it
  a_data_known : assert property (
    @(posedge sys_clk8) disable iff (!n_sys_reset8)
    latch_data |-> !$isunknown(data_smc)
  )
  else
    $error("latch_data with unknown data_smc");

endmodule

// ==== hdl/smc_access_counter.sv ====
// smc access counter
// captures the transfer size, counts the external accesses down, flags the last

`timescale 1ns/1ns

`include "smc_mac_consts.svh"

module smc_access_counter
(
  input  logic                     sys_clk8,       // system clock
  input  logic                     n_sys_reset8,   // async reset, active low
  input  logic                     valid_access,   // address cycle of new transfer
  input  smc_mac_pkg::xfer_size_t  xfer_size,      // valid with valid_access
  input  logic                     smc_done,       // end of one external access
  input  smc_mac_pkg::smc_state_t  smc_nextstate,  // fsm next state
  output smc_mac_pkg::acc_cnt_t    r_num_access,   // accesses still to go
  output smc_mac_pkg::xfer_size_t  r_xfer_size,    // stored size
  output smc_mac_pkg::xfer_size_t  v_xfer_size,    // size valid this cycle
  output logic                     mac_done        // last access
);

  smc_mac_pkg::acc_cnt_t num_accesses;    // load value for the counter
  logic                  dec_en;          // step to the next access

  // --------------------------------------------------------------------------
  // transfer size store
  // --------------------------------------------------------------------------
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
      r_xfer_size <= smc_mac_pkg::XFER_8;
    else if (valid_access)
      r_xfer_size <= xfer_size;         // held for the whole transfer
  end

  // live size in the address cycle, stored one after
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  // --------------------------------------------------------------------------
  // number of accesses, minus the first one
  // --------------------------------------------------------------------------
  always_comb
  begin
    case (xfer_size)
      smc_mac_pkg::XFER_16: num_accesses = smc_mac_pkg::acc_cnt_t'(1);  // two bytes
      smc_mac_pkg::XFER_32: num_accesses = smc_mac_pkg::acc_cnt_t'(3);  // four bytes
      default:              num_accesses = smc_mac_pkg::acc_cnt_t'(0);  // single byte
    endcase
  end

  // store and idle end the transfer, no more bytes to move
  assign dec_en = smc_done &&
                  (smc_nextstate != `SMC_STORE) &&
                  (smc_nextstate != `SMC_IDLE);

  // --------------------------------------------------------------------------
  // access counter
  // --------------------------------------------------------------------------
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
      r_num_access <= '0;
    else if (valid_access)
      r_num_access <= num_accesses;     // new transfer wins over a stray done
    else if (dec_en)
      r_num_access <= r_num_access - smc_mac_pkg::acc_cnt_t'(1);
  end

  // count at zero means this is the final access
  assign mac_done = (r_num_access == '0);

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  // the fsm must leave through store or idle once the last byte is reached,
  // otherwise the counter wraps to 3 and the next transfer starts misaligned
  a_no_underflow : assert property (
    @(posedge sys_clk8) disable iff (!n_sys_reset8)
    (dec_en && !valid_access) |-> (r_num_access != '0)
  )
  else
    $error("access counter decremented at zero");

endmodule

// ==== hdl/smc_mac_pkg.sv ====
// smc multiple-access control types
// transfer size, access count, data and fsm state types

`include "smc_mac_consts.svh"

package smc_mac_pkg;

  // --------------------------------------------------------------------------
  // transfer size, coded as on the internal bus
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    XFER_8  = `XSIZ_8,              // byte
    XFER_16 = `XSIZ_16,             // halfword
    XFER_32 = `XSIZ_32              // word
  } xfer_size_t;

  // accesses still to go after the current one
  typedef logic [`SMC_ACC_W-1:0] acc_cnt_t;

  // internal word
  typedef logic [`SMC_DATA_W-1:0] smc_word_t;

  // one byte on the external bus
  typedef logic [`SMC_BYTE_W-1:0] smc_byte_t;

  // fsm next state, one-hot
  typedef logic [`SMC_STATE_W-1:0] smc_state_t;

endpackage

// ==== hdl/smc_mac_consts.svh ====
// smc multiple-access control constants
// bus widths, counter width, fsm next-state codes and transfer size codes

`ifndef SMC_MAC_CONSTS_SVH
`define SMC_MAC_CONSTS_SVH

// --------------------------------------------------------------------------
// widths
// --------------------------------------------------------------------------
`define SMC_DATA_W   32           // internal ahb-side data
`define SMC_BYTE_W   8            // external memory bus, 8-bit only
`define SMC_ACC_W    2            // accesses still to go, up to 3
`define SMC_STATE_W  5            // one-hot fsm next state

// --------------------------------------------------------------------------
// fsm next-state codes, one-hot
// --------------------------------------------------------------------------
`define SMC_IDLE     5'b00001
`define SMC_LE       5'b00010     // address latch enable
`define SMC_RW       5'b00100     // read/write strobe phase
`define SMC_STORE    5'b01000     // last read byte being stored
`define SMC_FLOAT    5'b10000     // bus turnaround

// transfer size codes, 2'b11 reserved
`define XSIZ_8       2'd0
`define XSIZ_16      2'd1
`define XSIZ_32      2'd2

`endif
